// File: all.f
hw/soc_map_pkg.sv
hw/periph_pkg.sv
hw/bus_ctrl.sv
hw/rom_port.sv
hw/sensor_buffer.sv
hw/watchdog.sv
hw/periph_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_top -o tb_sim

./obj_dir/tb_sim > sim.log
cat sim.log

# Result is decided by the pass line in the log
grep -q '^\*\* PASS \*\*$' sim.log
echo "Simulation passed"

// File: testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int SENSOR_DEPTH = 8;
    localparam int WDT_W        = 16;
    localparam int WAIT_LIMIT   = 500;

    logic        clk;
    logic        rst;
    logic        req;
    logic        we;
    logic [15:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        rvalid;
    logic [31:0] ROM_out;
    logic        ROM_enable;
    logic        ROM_read;
    logic [11:0] ROM_address;
    logic        sensor_ready;
    logic [31:0] sensor_out;
    logic        sensor_en;
    logic        sensor_interrupt;
    logic        wto;
    int          test_num;
    logic        test_end;
    int          error_count;
    int          check_count;
    integer      seed;
    integer      sensor_seed;
    bit          timed_out;

    periph_top #(.SENSOR_DEPTH(SENSOR_DEPTH), .WDT_W(WDT_W)) dut_i (
        .clk(clk), .rst(rst), .req(req), .we(we), .addr(addr), .wdata(wdata),
        .rdata(rdata), .rvalid(rvalid), .ROM_out(ROM_out), .ROM_enable(ROM_enable),
        .ROM_read(ROM_read), .ROM_address(ROM_address), .sensor_ready(sensor_ready),
        .sensor_out(sensor_out), .sensor_en(sensor_en),
        .sensor_interrupt(sensor_interrupt), .wto(wto)
    );

    tb_checker #(.SENSOR_DEPTH(SENSOR_DEPTH), .WDT_W(WDT_W)) checker_i (
        .clk(clk), .rst(rst), .req(req), .we(we), .addr(addr), .wdata(wdata),
        .rdata(rdata), .rvalid(rvalid), .ROM_enable(ROM_enable), .ROM_read(ROM_read),
        .ROM_address(ROM_address), .sensor_ready(sensor_ready), .sensor_out(sensor_out),
        .sensor_en(sensor_en), .sensor_interrupt(sensor_interrupt), .wto(wto),
        .test_num(test_num), .test_end(test_end),
        .error_count(error_count), .check_count(check_count)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rom_word(input logic [11:0] a);
        return {a[3:0], ~a, a, 4'h5};
    endfunction

    // ROM answers one cycle after enable
    always @(posedge clk) begin
        if (ROM_enable) begin
            ROM_out <= rom_word(ROM_address);
        end
    end

    // Sensor with random ready pulses and data
    always @(posedge clk) begin
        sensor_ready <= ($random(sensor_seed) % 2) != 0;
        sensor_out   <= $random(sensor_seed);
    end

    task automatic bus_write(input logic [15:0] a, input logic [31:0] d);
        if (!timed_out) begin
            @(posedge clk);
            req   <= 1'b1;
            we    <= 1'b1;
            addr  <= a;
            wdata <= d;
            @(posedge clk);
            req <= 1'b0;
            we  <= 1'b0;
        end
    endtask

    task automatic bus_read(input logic [15:0] a);
        int n;
        n = 0;
        if (!timed_out) begin
            @(posedge clk);
            req  <= 1'b1;
            we   <= 1'b0;
            addr <= a;
            @(posedge clk);
            req <= 1'b0;
            @(negedge clk);
            while (!rvalid && n < 10) begin
                @(negedge clk);
                n++;
            end
            if (!rvalid) begin
                $display("Timeout: no read response for address %h", a);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_high(input bit use_wto, input string what);
        int n;
        n = 0;
        if (!timed_out) begin
            @(negedge clk);
            while (!(use_wto ? wto : sensor_interrupt) && n < WAIT_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (!(use_wto ? wto : sensor_interrupt)) begin
                $display("Timeout: %s never went high", what);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic finish_test();
        @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        test_num <= test_num + 1;
    endtask

    initial begin
        logic [31:0] r;
        int          i;
        seed         = 32'h5b3a;
        sensor_seed  = 32'h5b3a ^ 32'h1;
        clk          = 1'b0;
        rst          = 1'b1;
        req          = 1'b0;
        we           = 1'b0;
        addr         = '0;
        wdata        = '0;
        ROM_out      = '0;
        sensor_ready = 1'b0;
        sensor_out   = '0;
        test_num     = 1;
        test_end     = 1'b0;
        timed_out    = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Idle outputs after reset
        repeat (4) @(posedge clk);
        finish_test();

        for (i = 0; i < 20; i++) begin
            r = $random(seed);
            bus_read({4'h0, r[11:0]});
        end
        finish_test();

        // Fill the buffer, read it back, then clear
        bus_write(16'h1100, 32'h1);
        wait_high(1'b0, "sensor interrupt");
        bus_read(16'h1102);
        for (i = 0; i < SENSOR_DEPTH; i++) begin
            bus_read(16'h1000 + 16'(i));
        end
        bus_write(16'h1100, 32'h0);
        bus_write(16'h1101, 32'h0);
        bus_read(16'h1102);
        for (i = 0; i < SENSOR_DEPTH; i++) begin
            bus_read(16'h1000 + 16'(i));
        end
        finish_test();

        r = $random(seed);
        bus_write(16'h2001, 32'd16 + {26'd0, r[5:0]});
        bus_write(16'h2000, 32'h1);
        bus_read(16'h2003);
        wait_high(1'b1, "watchdog timeout");
        bus_read(16'h2003);
        bus_write(16'h2002, 32'h0);
        bus_read(16'h2003);
        bus_write(16'h2000, 32'h0);
        finish_test();

        // Mixed traffic with sensor and watchdog running
        bus_write(16'h1100, 32'h1);
        bus_write(16'h2001, 32'h0000_8000);
        bus_write(16'h2000, 32'h1);
        for (i = 0; i < 40; i++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0: bus_read({4'h1, r[13] ? 12'h102 : {8'h00, r[11:8]}});
                2'd1: bus_read({4'h2, 9'h000, r[10:8]});
                default: bus_read({r[4:2] == 3'd0 ? 4'h3 : {1'b1, r[4:2]}, r[31:20]});
            endcase
        end
        finish_test();

        // Let the checker finish its last edge before the summary
        @(negedge clk);
        $display("Tests: %0d, checks: %0d, errors: %0d", test_num - 1, check_count,
                 error_count);
        if (timed_out || error_count != 0) begin
            $display("** FAIL **");
        end else begin
            $display("** PASS **");
        end
        $finish;
    end

endmodule

// File: testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
    parameter int SENSOR_DEPTH = 8,
    parameter int WDT_W        = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic        we,
    input  logic [15:0] addr,
    input  logic [31:0] wdata,
    input  logic [31:0] rdata,
    input  logic        rvalid,
    input  logic        ROM_enable,
    input  logic        ROM_read,
    input  logic [11:0] ROM_address,
    input  logic        sensor_ready,
    input  logic [31:0] sensor_out,
    input  logic        sensor_en,
    input  logic        sensor_interrupt,
    input  logic        wto,
    input  int          test_num,
    input  logic        test_end,
    output int          error_count,
    output int          check_count
);
    import soc_map_pkg::*;
    import periph_pkg::*;

    logic [31:0]      buf_model [SENSOR_DEPTH];
    int               fill;
    logic             sens_en;
    logic             wdt_en;
    logic [WDT_W-1:0] wdt_load;
    logic [WDT_W-1:0] wdt_cnt;
    logic             rom_en_exp;
    logic [11:0]      rom_addr_exp;
    logic             pending;
    int               wait_cnt;
    int               exp_lat;
    logic [31:0]      exp_data;
    int               test_errors;

    // External ROM contents
    function automatic logic [31:0] rom_word(input logic [11:0] a);
        return {a[3:0], ~a, a, 4'h5};
    endfunction

    // Register map as seen by a local read
    function automatic logic [31:0] read_model(input logic [3:0] region, input logic [11:0] ofs);
        logic [31:0] v;
        v = '0;
        if (region == REGION_SENSOR) begin
            if (ofs == SENSOR_STATUS_OFS) begin
                v = {fill == SENSOR_DEPTH, 31'(fill)};
            end else if (int'(ofs) < fill) begin
                v = buf_model[int'(ofs)];
            end
        end else if (region == REGION_WDT && ofs == WDT_COUNT_OFS) begin
            v = 32'(wdt_cnt);
        end
        return v;
    endfunction

    task automatic expect_word(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            test_errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic expect_bit(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            test_errors++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    always @(posedge clk) begin
        logic        capture;
        logic [3:0]  region;
        logic [11:0] ofs;
        region = addr[15:12];
        ofs    = addr[11:0];
        if (rst) begin
            fill       = 0;
            sens_en    = 1'b0;
            wdt_en     = 1'b0;
            wdt_load   = '0;
            wdt_cnt    = '0;
            rom_en_exp = 1'b0;
            pending    = 1'b0;
        end else begin
            // Output levels against the state before this edge
            expect_bit("ROM_enable", ROM_enable, rom_en_exp);
            expect_bit("ROM_read", ROM_read, rom_en_exp);
            if (rom_en_exp) begin
                expect_word("ROM_address", {20'd0, ROM_address}, {20'd0, rom_addr_exp});
            end
            expect_bit("sensor_en", sensor_en, sens_en && fill < SENSOR_DEPTH);
            expect_bit("sensor_interrupt", sensor_interrupt, fill == SENSOR_DEPTH);
            expect_bit("wto", wto, wdt_en && wdt_cnt > wdt_load);

            if (pending) begin
                wait_cnt++;
                if (rvalid) begin
                    expect_word("read latency", wait_cnt, exp_lat);
                    expect_word("rdata", rdata, exp_data);
                    pending = 1'b0;
                end else if (wait_cnt > exp_lat) begin
                    $display("Read response missing %0d cycles after request, at %0t",
                             wait_cnt, $time);
                    error_count++;
                    test_errors++;
                    pending = 1'b0;
                end
            end else if (rvalid) begin
                $display("Read response without a request at %0t", $time);
                error_count++;
                test_errors++;
            end

            rom_en_exp = 1'b0;
            if (req && !we) begin
                pending  = 1'b1;
                wait_cnt = 0;
                if (region == REGION_ROM) begin
                    exp_lat      = 3;
                    exp_data     = rom_word(ofs);
                    rom_en_exp   = 1'b1;
                    rom_addr_exp = ofs;
                end else begin
                    exp_lat  = 1;
                    exp_data = read_model(region, ofs);
                end
            end

            // Sensor buffer, clear beats a capture
            capture = sensor_ready && sens_en && fill < SENSOR_DEPTH;
            if (req && we && region == REGION_SENSOR && ofs == SENSOR_CLEAR_OFS) begin
                fill = 0;
            end else if (capture) begin
                buf_model[fill] = sensor_out;
                fill++;
            end
            if (req && we && region == REGION_SENSOR && ofs == SENSOR_CTRL_OFS) begin
                sens_en = wdata[0];
            end

            // Watchdog counter saturates
            if (req && we && region == REGION_WDT &&
                (ofs == WDT_KICK_OFS || (ofs == WDT_EN_OFS && !wdata[0]))) begin
                wdt_cnt = '0;
            end else if (wdt_en && wdt_cnt != '1) begin
                wdt_cnt = wdt_cnt + 1'b1;
            end
            if (req && we && region == REGION_WDT && ofs == WDT_EN_OFS) begin
                wdt_en = wdata[0];
            end
            if (req && we && region == REGION_WDT && ofs == WDT_LOAD_OFS) begin
                wdt_load = wdata[WDT_W-1:0];
            end

            if (test_end) begin
                $display("Test %0d finished with %0d errors", test_num, test_errors);
                test_errors = 0;
            end
        end
    end

endmodule

// File: hw/periph_top.sv
`timescale 1ns/1ps

module periph_top #(
    parameter int SENSOR_DEPTH = 8,
    parameter int WDT_W        = 16
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                req,
    input  logic                                we,
    input  soc_map_pkg::bus_addr_u              addr,
    input  logic [periph_pkg::DATA_W-1:0]       wdata,
    output logic [periph_pkg::DATA_W-1:0]       rdata,
    output logic                                rvalid,
    input  logic [periph_pkg::DATA_W-1:0]       ROM_out,
    output logic                                ROM_enable,
    output logic                                ROM_read,
    output logic [soc_map_pkg::OFFSET_W-1:0]    ROM_address,
    input  logic                                sensor_ready,
    input  logic [periph_pkg::DATA_W-1:0]       sensor_out,
    output logic                                sensor_en,
    output logic                                sensor_interrupt,
    output logic                                wto
);
    import soc_map_pkg::*;
    import periph_pkg::*;

    localparam int IDX_W = $clog2(SENSOR_DEPTH);
    localparam int CNT_W = $clog2(SENSOR_DEPTH + 1);

    // ROM path
    logic                rom_rd;
    logic [OFFSET_W-1:0] rom_ofs;
    logic [DATA_W-1:0]   rom_data;
    logic                rom_valid;

    // Sensor path
    logic                sensor_en_wr;
    logic                sensor_en_val;
    logic                sensor_clear;
    logic [IDX_W-1:0]    buf_index;
    logic [DATA_W-1:0]   buf_data;
    logic [CNT_W-1:0]    fill_count;
    logic                full;

    // Watchdog path
    logic                wdt_en_wr;
    logic                wdt_load_wr;
    logic                wdt_kick;
    logic [DATA_W-1:0]   wdt_wdata;
    logic [DATA_W-1:0]   wdt_count;

    bus_ctrl #(.SENSOR_DEPTH(SENSOR_DEPTH)) bus_ctrl_i (
        .clk(clk), .rst(rst), .req(req), .we(we), .addr(addr), .wdata(wdata),
        .rdata(rdata), .rvalid(rvalid),
        .rom_rd(rom_rd), .rom_ofs(rom_ofs), .rom_data(rom_data), .rom_valid(rom_valid),
        .sensor_en_wr(sensor_en_wr), .sensor_en_val(sensor_en_val),
        .sensor_clear(sensor_clear), .buf_index(buf_index), .buf_data(buf_data),
        .fill_count(fill_count), .full(full),
        .wdt_en_wr(wdt_en_wr), .wdt_load_wr(wdt_load_wr), .wdt_kick(wdt_kick),
        .wdt_wdata(wdt_wdata), .wdt_count(wdt_count)
    );

    rom_port rom_port_i (
        .clk(clk), .rst(rst), .rom_rd(rom_rd), .rom_ofs(rom_ofs), .ROM_out(ROM_out),
        .ROM_enable(ROM_enable), .ROM_read(ROM_read), .ROM_address(ROM_address),
        .rom_data(rom_data), .rom_valid(rom_valid)
    );

    sensor_buffer #(.SENSOR_DEPTH(SENSOR_DEPTH)) sensor_buffer_i (
        .clk(clk), .rst(rst), .sensor_ready(sensor_ready), .sensor_out(sensor_out),
        .sensor_en(sensor_en), .sensor_interrupt(sensor_interrupt),
        .sensor_en_wr(sensor_en_wr), .sensor_en_val(sensor_en_val),
        .sensor_clear(sensor_clear), .buf_index(buf_index), .buf_data(buf_data),
        .fill_count(fill_count), .full(full)
    );

    watchdog #(.WDT_W(WDT_W)) watchdog_i (
        .clk(clk), .rst(rst), .wdt_en_wr(wdt_en_wr), .wdt_load_wr(wdt_load_wr),
        .wdt_kick(wdt_kick), .wdt_wdata(wdt_wdata), .wto(wto), .wdt_count(wdt_count)
    );

endmodule

// File: hw/watchdog.sv
`timescale 1ns/1ps

module watchdog #(
    parameter int WDT_W = 16
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wdt_en_wr,
    input  logic                            wdt_load_wr,
    input  logic                            wdt_kick,
    input  logic [periph_pkg::DATA_W-1:0]   wdt_wdata,
    output logic                            wto,
    output logic [periph_pkg::DATA_W-1:0]   wdt_count
);
    import periph_pkg::*;

    logic             en;
    logic [WDT_W-1:0] load_val;
    logic [WDT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            en       <= 1'b0;
            load_val <= '0;
            count    <= '0;
        end else begin
            if (wdt_en_wr) begin
                en <= wdt_wdata[0];
            end
            if (wdt_load_wr) begin
                load_val <= wdt_wdata[WDT_W-1:0];
            end
            // Kick and disable both restart the count
            if (wdt_kick || (wdt_en_wr && !wdt_wdata[0])) begin
                count <= '0;
            end else if (en && count != '1) begin
                count <= count + 1'b1;
            end
        end
    end

    assign wto       = en & (count > load_val);
    assign wdt_count = DATA_W'(count);

endmodule

// File: hw/sensor_buffer.sv
`timescale 1ns/1ps

module sensor_buffer #(
    parameter int SENSOR_DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                sensor_ready,
    input  logic [periph_pkg::DATA_W-1:0]       sensor_out,
    output logic                                sensor_en,
    output logic                                sensor_interrupt,
    input  logic                                sensor_en_wr,
    input  logic                                sensor_en_val,
    input  logic                                sensor_clear,
    input  logic [$clog2(SENSOR_DEPTH)-1:0]     buf_index,
    output logic [periph_pkg::DATA_W-1:0]       buf_data,
    output logic [$clog2(SENSOR_DEPTH+1)-1:0]   fill_count,
    output logic                                full
);
    import periph_pkg::*;

    localparam int IDX_W = $clog2(SENSOR_DEPTH);
    localparam int CNT_W = $clog2(SENSOR_DEPTH + 1);

    logic              en_reg;
    logic [CNT_W-1:0]  wr_ptr;
    logic              capture;
    logic [DATA_W-1:0] mem [SENSOR_DEPTH];

    assign full             = (wr_ptr == CNT_W'(SENSOR_DEPTH));
    assign sensor_en        = en_reg & ~full;
    assign sensor_interrupt = full;
    assign capture          = sensor_ready & sensor_en;
    assign fill_count       = wr_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            en_reg <= 1'b0;
            wr_ptr <= '0;
        end else begin
            if (sensor_en_wr) begin
                en_reg <= sensor_en_val;
            end
            // Clear wins over a capture in the same cycle
            if (sensor_clear) begin
                wr_ptr <= '0;
            end else if (capture) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // Words fill in arrival order
    always_ff @(posedge clk) begin
        if (capture && !sensor_clear) begin
            mem[wr_ptr[IDX_W-1:0]] <= sensor_out;
        end
    end

    // Stale entries past the fill count stay hidden
    assign buf_data = (CNT_W'(buf_index) < wr_ptr) ? mem[buf_index] : '0;

    // A full buffer stays full until cleared, nothing more is taken in
    a_no_capture_when_full: assert property (
        @(posedge clk) disable iff (rst) (full && !sensor_clear) |=> full
    );

endmodule

// File: hw/rom_port.sv
`timescale 1ns/1ps

module rom_port (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rom_rd,
    input  logic [soc_map_pkg::OFFSET_W-1:0]    rom_ofs,
    input  logic [periph_pkg::DATA_W-1:0]       ROM_out,
    output logic                                ROM_enable,
    output logic                                ROM_read,
    output logic [soc_map_pkg::OFFSET_W-1:0]    ROM_address,
    output logic [periph_pkg::DATA_W-1:0]       rom_data,
    output logic                                rom_valid
);

    logic rom_wait;

    // Registered ROM control, address held between accesses
    always_ff @(posedge clk) begin
        if (rst) begin
            ROM_enable  <= 1'b0;
            ROM_read    <= 1'b0;
            ROM_address <= '0;
            rom_wait    <= 1'b0;
            rom_valid   <= 1'b0;
        end else begin
            ROM_enable <= rom_rd;
            ROM_read   <= rom_rd;
            if (rom_rd) begin
                ROM_address <= rom_ofs;
            end
            // ROM drives its output one cycle after enable
            rom_wait  <= ROM_enable;
            rom_valid <= rom_wait;
        end
    end

    always_ff @(posedge clk) begin
        if (rom_wait) begin
            rom_data <= ROM_out;
        end
    end

    // Read only with enable, and the access lasts a single cycle
    a_rom_read_pulse: assert property (
        @(posedge clk) disable iff (rst) ROM_read |-> ROM_enable ##1 !ROM_enable
    );

endmodule

// File: hw/bus_ctrl.sv
`timescale 1ns/1ps

module bus_ctrl #(
    parameter int SENSOR_DEPTH = 8
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    req,
    input  logic                                    we,
    input  soc_map_pkg::bus_addr_u                  addr,
    input  logic [periph_pkg::DATA_W-1:0]           wdata,
    output logic [periph_pkg::DATA_W-1:0]           rdata,
    output logic                                    rvalid,
    output logic                                    rom_rd,
    output logic [soc_map_pkg::OFFSET_W-1:0]        rom_ofs,
    input  logic [periph_pkg::DATA_W-1:0]           rom_data,
    input  logic                                    rom_valid,
    output logic                                    sensor_en_wr,
    output logic                                    sensor_en_val,
    output logic                                    sensor_clear,
    output logic [$clog2(SENSOR_DEPTH)-1:0]         buf_index,
    input  logic [periph_pkg::DATA_W-1:0]           buf_data,
    input  logic [$clog2(SENSOR_DEPTH+1)-1:0]       fill_count,
    input  logic                                    full,
    output logic                                    wdt_en_wr,
    output logic                                    wdt_load_wr,
    output logic                                    wdt_kick,
    output logic [periph_pkg::DATA_W-1:0]           wdt_wdata,
    input  logic [periph_pkg::DATA_W-1:0]           wdt_count
);
    import soc_map_pkg::*;
    import periph_pkg::*;

    localparam int IDX_W = $clog2(SENSOR_DEPTH);
    localparam int CNT_W = $clog2(SENSOR_DEPTH + 1);

    logic                is_rom;
    logic                is_sensor;
    logic                is_wdt;
    logic                wr_req;
    logic                rd_req;
    logic [OFFSET_W-1:0] ofs;
    logic [DATA_W-1:0]   rd_mux;
    logic [DATA_W-1:0]   rd_data_q;
    logic                rd_valid_q;
    logic                read_pending;

    // Region decode through the field view
    assign is_rom    = (addr.field.region == REGION_ROM);
    assign is_sensor = (addr.field.region == REGION_SENSOR);
    assign is_wdt    = (addr.field.region == REGION_WDT);
    assign ofs       = addr.field.offset;
    assign wr_req    = req & we;
    assign rd_req    = req & ~we;

    // One strobe per request
    assign rom_rd       = rd_req & is_rom;
    assign rom_ofs      = addr.raw[OFFSET_W-1:0];
    assign sensor_en_wr = wr_req & is_sensor & (ofs == SENSOR_CTRL_OFS);
    assign sensor_clear = wr_req & is_sensor & (ofs == SENSOR_CLEAR_OFS);
    assign wdt_en_wr    = wr_req & is_wdt & (ofs == WDT_EN_OFS);
    assign wdt_load_wr  = wr_req & is_wdt & (ofs == WDT_LOAD_OFS);
    assign wdt_kick     = wr_req & is_wdt & (ofs == WDT_KICK_OFS);

    assign sensor_en_val = wdata[0];
    assign wdt_wdata     = wdata;
    assign buf_index     = ofs[IDX_W-1:0];

    // Local read mux, anything unmapped reads zero
    always_comb begin
        rd_mux = '0;
        if (is_sensor) begin
            if (ofs == SENSOR_STATUS_OFS) begin
                rd_mux[CNT_W-1:0]  = fill_count;
                rd_mux[DATA_W-1]   = full;
            end else if (ofs < OFFSET_W'(SENSOR_DEPTH)) begin
                rd_mux = buf_data;
            end
        end else if (is_wdt && ofs == WDT_COUNT_OFS) begin
            rd_mux = wdt_count;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid_q   <= 1'b0;
            read_pending <= 1'b0;
        end else begin
            rd_valid_q   <= rd_req & ~is_rom;
            read_pending <= rd_req | (read_pending & ~rvalid);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req && !is_rom) begin
            rd_data_q <= rd_mux;
        end
    end

    // ROM data arrives from rom_port and is forwarded in the same cycle
    assign rvalid = rd_valid_q | rom_valid;
    assign rdata  = rom_valid ? rom_data : rd_data_q;

    // Requester waits for the response of an outstanding read
    a_no_req_while_pending: assert property (
        @(posedge clk) disable iff (rst) req |-> (!read_pending || rvalid)
    );

endmodule

// File: hw/periph_pkg.sv
package periph_pkg;

    // Register bus data width
    localparam int DATA_W = 32;

    // Sensor region
    // Offsets below the buffer depth read the captured words
    localparam logic [11:0] SENSOR_CTRL_OFS   = 12'h100;
    localparam logic [11:0] SENSOR_CLEAR_OFS  = 12'h101;
    // Fill count in the low bits, full flag in bit 31
    localparam logic [11:0] SENSOR_STATUS_OFS = 12'h102;

    // Watchdog region
    localparam logic [11:0] WDT_EN_OFS    = 12'h000;
    localparam logic [11:0] WDT_LOAD_OFS  = 12'h001;
    localparam logic [11:0] WDT_KICK_OFS  = 12'h002;
    localparam logic [11:0] WDT_COUNT_OFS = 12'h003;

endpackage

// File: hw/soc_map_pkg.sv
package soc_map_pkg;

    // Bus address split into a region nibble and a 12-bit offset
    localparam int ADDR_W   = 16;
    localparam int REGION_W = 4;
    localparam int OFFSET_W = 12;

    // Region codes in the top nibble of the address
    localparam logic [REGION_W-1:0] REGION_ROM    = 4'd0;
    localparam logic [REGION_W-1:0] REGION_SENSOR = 4'd1;
    localparam logic [REGION_W-1:0] REGION_WDT    = 4'd2;

    // Remaining region codes are unmapped and read as zero

    typedef struct packed {
        logic [REGION_W-1:0] region;
        logic [OFFSET_W-1:0] offset;
    } bus_addr_fields_t;

    // Same address word, seen raw or as region/offset
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        bus_addr_fields_t  field;
    } bus_addr_u;

endpackage
